/* compile.f */
logic/nes_pkg.sv
logic/spi_load_capture.sv
logic/reset_sequencer.sv
logic/mem_arbiter.sv
logic/game_ram.sv
logic/joypad_shifter.sv
logic/audio_dac.sv
logic/nes_board_core.sv
testbench/nes_checker.sv
testbench/tb_nes_board.sv

/* testbench/tb_nes_board.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_nes_board;

  localparam int GAME_ADDR_BITS = 12;
  localparam int LOAD_BYTES     = 64;
  localparam int CTRL_EVERY     = 8;      // control write after every 8th game byte
  localparam int BYTE_GAP       = 8;
  localparam int AUDIO_WINDOW   = 4096;
  localparam int LOAD_CYCLES    = (LOAD_BYTES + LOAD_BYTES / CTRL_EVERY + 2) * BYTE_GAP;
  localparam int TIMEOUT_CYCLES = 2 * LOAD_CYCLES + 2 * (nes_pkg::DOWNLOAD_HOLD + 4)
                                  + 2 * (AUDIO_WINDOW + 8) + 3000;

  logic                 clock;
  logic                 i_reset;
  nes_pkg::host_write_t host;
  nes_pkg::mem_req_t    cpu_req;
  logic [6:0]           btn;
  nes_pkg::buttons_t    usb_buttons;
  logic                 joy_strobe;
  logic                 joy_clock;
  nes_pkg::sample_t     sample;
  nes_pkg::byte_t       o_cpu_data;
  logic                 o_load_done;
  logic                 o_nes_reset;
  logic                 o_joy_data;
  nes_pkg::dac_t        o_audio;

  logic [GAME_ADDR_BITS-1:0] load_addr [LOAD_BYTES];
  bit                        addr_used [2**GAME_ADDR_BITS];

  nes_board_core #(
    .GAME_ADDR_BITS (GAME_ADDR_BITS),
    .LOAD_BYTES     (LOAD_BYTES)
  ) u_dut (
    .clock         (clock),
    .i_reset       (i_reset),
    .i_host        (host),
    .i_cpu_req     (cpu_req),
    .i_btn         (btn),
    .i_usb_buttons (usb_buttons),
    .i_joy_strobe  (joy_strobe),
    .i_joy_clock   (joy_clock),
    .i_sample      (sample),
    .o_cpu_data    (o_cpu_data),
    .o_load_done   (o_load_done),
    .o_nes_reset   (o_nes_reset),
    .o_joy_data    (o_joy_data),
    .o_audio       (o_audio)
  );

  nes_checker u_chk (
    .clock       (clock),
    .i_reset     (i_reset),
    .i_load_done (o_load_done),
    .i_nes_reset (o_nes_reset),
    .i_sample    (sample),
    .i_audio     (o_audio)
  );

  always #20 clock = ~clock;

  // game image content mixing every address bit
  function automatic nes_pkg::byte_t game_byte(input int unsigned addr, input int unsigned pass);
    logic [31:0] h;
    h = addr * 32'h9E3779B1 + pass * 32'h7F4A7C15;
    h = h ^ (h >> 15);
    return h[7:0] ^ h[23:16];
  endfunction

  // usb vector with each pressed board button added at its console slot
  function automatic nes_pkg::buttons_t merged_buttons(input logic [6:0] b,
                                                       input nes_pkg::buttons_t usb);
    nes_pkg::buttons_t v;
    v    = usb;
    v[0] = v[0] | b[2];                   // a
    v[1] = v[1] | b[1];                   // b
    v[3] = v[3] | ~b[0];                  // start pressed when low
    v[4] = v[4] | b[3];                   // up
    v[5] = v[5] | b[4];                   // down
    v[6] = v[6] | b[5];                   // left
    v[7] = v[7] | b[6];                   // right
    return v;
  endfunction

  function automatic logic joy_bit(input nes_pkg::buttons_t v, input int k);
    return (k < 8) ? v[k] : 1'b0;         // zeros after the eighth bit
  endfunction

  function automatic int audio_carries(input nes_pkg::sample_t s, input int cycles);
    return (cycles * int'(s[nes_pkg::DITHER_BITS-1:0])) / (1 << nes_pkg::DITHER_BITS);
  endfunction

  task automatic host_write(input nes_pkg::host_addr_t addr, input nes_pkg::byte_t data);
    @(posedge clock);
    #2;
    host.wr   = 1'b1;
    host.addr = addr;
    host.data = data;
    @(posedge clock);
    #2;
    host.wr = 1'b0;
    repeat (BYTE_GAP - 2) @(posedge clock);
  endtask

  task automatic load_game(input int unsigned pass);
    nes_pkg::byte_t ctrl_data;
    for (int i = 0; i < LOAD_BYTES; i++)
    begin
      host_write(nes_pkg::host_addr_t'(load_addr[i]), game_byte(load_addr[i], pass));
      if ((i + 1) % CTRL_EVERY == 0)
      begin
        ctrl_data = ~game_byte(load_addr[i], pass) & 8'hFE;   // bit 0 clear and never the game byte
        host_write({nes_pkg::CONTROL_PAGE, 24'(load_addr[i])}, ctrl_data);
      end
    end
  endtask

  task automatic wait_for_done(input string what);
    int n;
    n = 0;
    while (o_load_done !== 1'b1 && n < 32)
    begin
      @(negedge clock);
      n++;
    end
    if (o_load_done !== 1'b1)
      u_chk.note_failure({"load done never rose after the ", what});
  endtask

  task automatic wait_for_release(input string what);
    int n;
    n = 0;
    while (o_nes_reset !== 1'b0 && n < nes_pkg::DOWNLOAD_HOLD + 8)
    begin
      @(negedge clock);
      n++;
    end
    if (o_nes_reset !== 1'b0)
      u_chk.note_failure({"console reset never released after the ", what});
  endtask

  task automatic cpu_read_check(input string name, input int unsigned addr,
                                input nes_pkg::byte_t exp);
    @(posedge clock);
    #2;
    cpu_req      = '0;
    cpu_req.re   = 1'b1;
    cpu_req.addr = nes_pkg::mem_addr_t'(addr);
    @(posedge clock);
    #2;
    cpu_req = '0;
    @(negedge clock);                     // one cycle after the request
    u_chk.compare(name, exp, o_cpu_data);
  endtask

  task automatic cpu_write(input int unsigned addr, input nes_pkg::byte_t data);
    @(posedge clock);
    #2;
    cpu_req      = '0;
    cpu_req.we   = 1'b1;
    cpu_req.addr = nes_pkg::mem_addr_t'(addr);
    cpu_req.data = data;
    @(posedge clock);
    #2;
    cpu_req = '0;
  endtask

  task automatic joypad_round();
    nes_pkg::buttons_t vec;
    @(posedge clock);
    #2;
    btn         = 7'($urandom);
    usb_buttons = 8'($urandom);
    vec         = merged_buttons(btn, usb_buttons);
    @(posedge clock);
    #2;
    joy_strobe = 1'b1;
    @(posedge clock);
    #2;
    joy_strobe = 1'b0;
    @(negedge clock);
    u_chk.compare("joypad_bit0", joy_bit(vec, 0), o_joy_data);
    for (int k = 1; k <= 10; k++)
    begin
      @(posedge clock);
      #2;
      joy_clock = 1'b1;
      @(posedge clock);
      #2;
      joy_clock = 1'b0;
      @(posedge clock);                   // falling edge seen here
      @(negedge clock);
      u_chk.compare($sformatf("joypad_bit%0d", k), joy_bit(vec, k), o_joy_data);
    end
  endtask

  task automatic audio_window(input nes_pkg::sample_t s);
    @(posedge clock);
    #2;
    sample = s;
    repeat (3) @(posedge clock);
    #2;
    u_chk.start_audio_window();
    repeat (AUDIO_WINDOW) @(posedge clock);
    #2;
    u_chk.end_audio_window("audio_carries", audio_carries(s, AUDIO_WINDOW));
  endtask

  initial
  begin
    int unsigned a;
    nes_pkg::byte_t wdata;
    void'($urandom(32'hdc994448));
    clock       = 1'b0;
    i_reset     = 1'b1;
    host        = '0;
    cpu_req     = '0;
    btn         = '0;
    usb_buttons = '0;
    joy_strobe  = 1'b0;
    joy_clock   = 1'b0;
    sample      = '0;
    repeat (3) @(posedge clock);
    #2;
    i_reset = 1'b0;

    for (int i = 0; i < LOAD_BYTES; i++)
    begin
      do
        a = $urandom % (1 << GAME_ADDR_BITS);
      while (addr_used[a]);
      addr_used[a] = 1;
      load_addr[i] = GAME_ADDR_BITS'(a);
    end

    load_game(0);                         // load, read back, reset timing
    wait_for_done("first load");
    for (int i = 0; i < LOAD_BYTES; i++)
      cpu_read_check("load_readback", load_addr[i], game_byte(load_addr[i], 0));
    wait_for_release("first load");

    wdata = game_byte(load_addr[3], 0) ^ 8'($urandom | 1);   // differs from the loaded byte
    cpu_write(load_addr[3], wdata);
    cpu_read_check("cpu_write", load_addr[3], wdata);

    repeat (2) joypad_round();

    audio_window(16'($urandom));
    audio_window({4'hF, 12'($urandom)});  // top code wraps

    host_write({nes_pkg::CONTROL_PAGE, 24'h0}, 8'h01);
    @(negedge clock);
    u_chk.compare("control_reset_done", 0, o_load_done);
    u_chk.compare("control_reset_hold", 1, o_nes_reset);
    host_write({nes_pkg::CONTROL_PAGE, 24'h0}, 8'h00);
    load_game(1);
    wait_for_done("reload");
    wait_for_release("reload");
    for (int i = 0; i < 8; i++)
      cpu_read_check("reload_readback", load_addr[i], game_byte(load_addr[i], 1));

    u_chk.report_counts();
    if (u_chk.error_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/nes_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module nes_checker (
  input wire                   clock,
  input wire                   i_reset,
  input wire                   i_load_done,
  input wire                   i_nes_reset,
  input wire nes_pkg::sample_t i_sample,
  input wire nes_pkg::dac_t    i_audio
);

  localparam int HOLD = nes_pkg::DOWNLOAD_HOLD;

  int               error_count = 0;
  int               check_count = 0;
  int               done_cycles = 0;      // negedges seen with load done high
  bit               late_reported = 0;
  logic             nes_reset_q = 1'b1;
  logic             run_q = 1'b0;         // console ran at the last edge
  nes_pkg::sample_t sample_q = '0;
  nes_pkg::dac_t    upper_q;
  int               carry_count = 0;
  bit               window_on = 0;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic note_failure(input string what);
    error_count++;
    $display("%s", what);
  endtask

  task automatic start_audio_window();
    carry_count = 0;
    window_on   = 1;
  endtask

  task automatic end_audio_window(input string name, input int exp);
    window_on = 0;
    compare(name, exp, carry_count);
  endtask

  task automatic report_counts();
    $display("checks: %0d, errors: %0d", check_count, error_count);
  endtask

  // outputs are settled at the falling edge
  always @(negedge clock)
  begin
    upper_q = sample_q[15:12];
    if (!i_reset)
    begin
      if (!i_nes_reset && (!i_load_done || done_cycles < HOLD))
        note_failure($sformatf("console reset released early, %0d cycles after load done",
                               done_cycles));
      if (nes_reset_q && !i_nes_reset && i_load_done)
      begin
        check_count++;                    // release edge
        if (done_cycles > HOLD + 2)
        begin
          error_count++;
          $display("[ERROR] reset_release: expected %0d..%0d, actual %0d",
                   HOLD, HOLD + 2, done_cycles);
        end
      end
      if (i_nes_reset && i_load_done && done_cycles > HOLD + 2 && !late_reported)
      begin
        late_reported = 1;
        note_failure("console reset still held after the download hold ran out");
      end
      if (run_q && i_audio !== upper_q && i_audio !== nes_pkg::dac_t'(upper_q + 4'd1))
      begin
        error_count++;
        $display("[ERROR] audio_range: expected 0x%0h or next code, actual 0x%0h",
                 upper_q, i_audio);
      end
      if (window_on && run_q && i_audio === nes_pkg::dac_t'(upper_q + 4'd1))
        carry_count++;
    end
    if (!i_load_done)
    begin
      done_cycles   = 0;
      late_reported = 0;
    end
    else
      done_cycles = done_cycles + 1;
    nes_reset_q = i_nes_reset;
    run_q       = !i_reset && !i_nes_reset;   // hold state seen by the next dac update
    sample_q    = i_sample;
  end

endmodule

`default_nettype wire

/* logic/nes_board_core.sv */
`timescale 1ns/1ps
`default_nettype none

module nes_board_core #(
  parameter int GAME_ADDR_BITS = 12,
  parameter int LOAD_BYTES     = 64
) (
  input  wire                  clock,
  input  wire                  i_reset,
  input  nes_pkg::host_write_t i_host,
  input  nes_pkg::mem_req_t    i_cpu_req,
  input  wire  [6:0]           i_btn,
  input  nes_pkg::buttons_t    i_usb_buttons,
  input  wire                  i_joy_strobe,
  input  wire                  i_joy_clock,
  input  nes_pkg::sample_t     i_sample,
  output nes_pkg::byte_t       o_cpu_data,
  output logic                 o_load_done,
  output logic                 o_nes_reset,
  output logic                 o_joy_data,
  output nes_pkg::dac_t        o_audio
);

  logic               byte_stb;
  nes_pkg::mem_addr_t byte_addr;
  nes_pkg::byte_t     byte_data;
  logic               first_byte;
  logic               sys_reset;
  nes_pkg::mem_req_t  mem_req;

  spi_load_capture #(
    .LOAD_BYTES (LOAD_BYTES)
  ) u_capture (
    .clock        (clock),
    .i_reset      (i_reset),
    .i_host       (i_host),
    .o_byte_stb   (byte_stb),
    .o_byte_addr  (byte_addr),
    .o_byte_data  (byte_data),
    .o_first_byte (first_byte),
    .o_load_done  (o_load_done),
    .o_sys_reset  (sys_reset)
  );

  reset_sequencer u_reset_seq (
    .clock        (clock),
    .i_reset      (i_reset),
    .i_first_byte (first_byte),
    .i_load_done  (o_load_done),
    .i_sys_reset  (sys_reset),
    .o_nes_reset  (o_nes_reset)
  );

  mem_arbiter #(
    .GAME_ADDR_BITS (GAME_ADDR_BITS)
  ) u_arbiter (
    .clock       (clock),
    .i_reset     (i_reset),
    .i_byte_stb  (byte_stb),
    .i_byte_addr (byte_addr),
    .i_byte_data (byte_data),
    .i_load_done (o_load_done),
    .i_cpu_req   (i_cpu_req),
    .o_mem_req   (mem_req)
  );

  game_ram #(
    .GAME_ADDR_BITS (GAME_ADDR_BITS)
  ) u_ram (
    .clock   (clock),
    .i_req   (mem_req),
    .o_rdata (o_cpu_data)
  );

  joypad_shifter u_joypad (
    .clock         (clock),
    .i_reset       (i_reset),
    .i_btn         (i_btn),
    .i_usb_buttons (i_usb_buttons),
    .i_joy_strobe  (i_joy_strobe),
    .i_joy_clock   (i_joy_clock),
    .o_joy_data    (o_joy_data)
  );

  audio_dac u_audio (
    .clock    (clock),
    .i_hold   (o_nes_reset),
    .i_sample (i_sample),
    .o_audio  (o_audio)
  );

endmodule

`default_nettype wire

/* logic/audio_dac.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_dac (
  input  wire              clock,
  input  wire              i_hold,
  input  nes_pkg::sample_t i_sample,
  output nes_pkg::dac_t    o_audio
);

  localparam int DB    = nes_pkg::DITHER_BITS;
  localparam int OUT_W = $bits(nes_pkg::dac_t);

  logic [DB-1:0] acc;
  logic [DB:0]   sum;
  nes_pkg::dac_t upper;

  assign upper = i_sample[$bits(nes_pkg::sample_t)-1 -: OUT_W];
  assign sum   = {1'b0, acc} + {1'b0, i_sample[DB-1:0]};

  always_ff @(posedge clock)
  begin
    if (i_hold)
      acc <= '0;
    else
      acc <= sum[DB-1:0];                   // first-order error feedback
  end

  // carry picks the next code up, wraps at the top
  always_ff @(posedge clock)
  begin
    if (sum[DB] && !i_hold)
      o_audio <= upper + 1'b1;
    else
      o_audio <= upper;
  end

endmodule

`default_nettype wire

/* logic/joypad_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module joypad_shifter (
  input  wire               clock,
  input  wire               i_reset,
  input  wire  [6:0]        i_btn,
  input  nes_pkg::buttons_t i_usb_buttons,
  input  wire               i_joy_strobe,
  input  wire               i_joy_clock,
  output logic              o_joy_data
);

  nes_pkg::buttons_t board_buttons;
  nes_pkg::buttons_t merged_q;
  nes_pkg::buttons_t shift_reg;
  logic              joy_clock_q;
  logic              joy_clock_fall;

  // onboard buttons in console order, no select button on the board
  assign board_buttons = {
    i_btn[6],    // right
    i_btn[5],    // left
    i_btn[4],    // down
    i_btn[3],    // up
    ~i_btn[0],   // start is active low
    1'b0,        // select
    i_btn[1],    // b
    i_btn[2]     // a
  };

  assign joy_clock_fall = !i_joy_clock && joy_clock_q;

  always_ff @(posedge clock)
  begin
    merged_q <= board_buttons | i_usb_buttons;
  end

  always_ff @(posedge clock)
  begin
    if (i_reset)
    begin
      joy_clock_q <= 1'b0;
      shift_reg   <= '0;
    end
    else
    begin
      joy_clock_q <= i_joy_clock;
      if (i_joy_strobe)
        shift_reg <= merged_q;                    // latch while strobe held
      else if (joy_clock_fall)
        shift_reg <= {1'b0, shift_reg[7:1]};      // next button out
    end
  end

  assign o_joy_data = shift_reg[0];

endmodule

`default_nettype wire

/* logic/game_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module game_ram #(
  parameter int GAME_ADDR_BITS = 12
) (
  input  wire               clock,
  input  nes_pkg::mem_req_t i_req,
  output nes_pkg::byte_t    o_rdata
);

  nes_pkg::byte_t            mem [2**GAME_ADDR_BITS];
  logic [GAME_ADDR_BITS-1:0] addr;

  assign addr = i_req.addr[GAME_ADDR_BITS-1:0];

  always_ff @(posedge clock)
  begin
    if (i_req.we)
      mem[addr] <= i_req.data;
    if (i_req.re)
      o_rdata <= mem[addr];                 // held when no read
  end

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
  parameter int GAME_ADDR_BITS = 12
) (
  input  wire                clock,
  input  wire                i_reset,
  input  wire                i_byte_stb,
  input  nes_pkg::mem_addr_t i_byte_addr,
  input  nes_pkg::byte_t     i_byte_data,
  input  wire                i_load_done,
  input  nes_pkg::mem_req_t  i_cpu_req,
  output nes_pkg::mem_req_t  o_mem_req
);

  nes_pkg::phase_t           phase;
  logic                      staged;
  logic [GAME_ADDR_BITS-1:0] stage_addr;
  nes_pkg::byte_t            stage_data;
  logic                      commit;
  logic                      cpu_grant;

  assign commit = staged && (phase == nes_pkg::COMMIT_PHASE);

  // a pending loader byte keeps the port until it lands
  assign cpu_grant = i_load_done && !staged;

  always_ff @(posedge clock)
  begin
    if (i_reset)
    begin
      phase  <= '0;
      staged <= 1'b0;
    end
    else
    begin
      phase <= phase + 2'd1;                // free-running clock-enable phase
      if (commit)
        staged <= 1'b0;
      if (i_byte_stb)
        staged <= 1'b1;                     // new byte wins over a same-cycle commit
    end
  end

  always_ff @(posedge clock)
  begin
    if (i_byte_stb)
    begin
      stage_addr <= i_byte_addr[GAME_ADDR_BITS-1:0];
      stage_data <= i_byte_data;
    end
  end

  always_comb
  begin
    o_mem_req = '0;
    if (cpu_grant)
      o_mem_req = i_cpu_req;                // cpu owns the port after the load
    else if (commit)
    begin
      o_mem_req.we                       = 1'b1;
      o_mem_req.addr[GAME_ADDR_BITS-1:0] = stage_addr;
      o_mem_req.data                     = stage_data;
    end
  end

endmodule

`default_nettype wire

/* logic/reset_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer (
  input  wire  clock,
  input  wire  i_reset,
  input  wire  i_first_byte,
  input  wire  i_load_done,
  input  wire  i_sys_reset,
  output logic o_nes_reset
);

  localparam int HOLD_W = $clog2(nes_pkg::DOWNLOAD_HOLD + 1);

  logic              init_hold;
  logic [HOLD_W-1:0] hold_count;

  always_ff @(posedge clock)
  begin
    if (i_reset)
    begin
      init_hold  <= 1'b1;
      hold_count <= HOLD_W'(nes_pkg::DOWNLOAD_HOLD);
    end
    else
    begin
      if (i_first_byte)
        init_hold <= 1'b0;                 // download has started
      if (!i_load_done)
        hold_count <= HOLD_W'(nes_pkg::DOWNLOAD_HOLD);
      else if (hold_count != '0)
        hold_count <= hold_count - 1'b1;   // post-load settle
    end
  end

  // console runs only with every source released
  assign o_nes_reset = !i_load_done || init_hold || (hold_count != '0) || i_sys_reset;

endmodule

`default_nettype wire

/* logic/spi_load_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_load_capture #(
  parameter int LOAD_BYTES = 64
) (
  input  wire                 clock,
  input  wire                 i_reset,
  input  nes_pkg::host_write_t i_host,
  output logic                o_byte_stb,
  output nes_pkg::mem_addr_t  o_byte_addr,
  output nes_pkg::byte_t      o_byte_data,
  output logic                o_first_byte,
  output logic                o_load_done,
  output logic                o_sys_reset
);

  localparam int COUNT_W = $clog2(LOAD_BYTES + 1);

  logic                 wr_q;
  logic                 wr_rise;
  logic                 is_control;
  logic                 game_rise;
  logic                 seen_first;
  logic [COUNT_W-1:0]   load_count;
  nes_pkg::byte_t       ctrl_reg;

  assign wr_rise    = i_host.wr & ~wr_q;
  assign is_control = (i_host.addr[31:24] == nes_pkg::CONTROL_PAGE);
  assign game_rise  = wr_rise & ~is_control;

  always_ff @(posedge clock)
  begin
    if (i_reset)
    begin
      wr_q         <= 1'b0;
      ctrl_reg     <= '0;
      o_byte_stb   <= 1'b0;
      o_first_byte <= 1'b0;
      seen_first   <= 1'b0;
      load_count   <= '0;
    end
    else
    begin
      wr_q         <= i_host.wr;
      o_byte_stb   <= game_rise;
      o_first_byte <= game_rise & ~seen_first;
      if (game_rise)
        seen_first <= 1'b1;
      if (wr_rise && is_control)
        ctrl_reg <= i_host.data;           // host control register
      if (ctrl_reg[0])
        load_count <= '0;                  // forced reset restarts the load
      else if (game_rise && load_count != COUNT_W'(LOAD_BYTES))
        load_count <= load_count + 1'b1;
    end
  end

  // game byte payload, follows the strobe
  always_ff @(posedge clock)
  begin
    if (game_rise)
    begin
      o_byte_addr <= i_host.addr[$bits(nes_pkg::mem_addr_t)-1:0];
      o_byte_data <= i_host.data;
    end
  end

  assign o_load_done = (load_count == COUNT_W'(LOAD_BYTES)) && !ctrl_reg[0];
  assign o_sys_reset = ctrl_reg[0];

endmodule

`default_nettype wire

/* logic/nes_pkg.sv */
`default_nettype none

package nes_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] host_addr_t;
  typedef logic [15:0] sample_t;
  typedef logic [3:0]  dac_t;
  typedef logic [7:0]  buttons_t;   // {right, left, down, up, start, select, b, a}
  typedef logic [1:0]  phase_t;
  typedef logic [21:0] mem_addr_t;  // widest game address, modules use the low bits

  localparam byte_t  CONTROL_PAGE  = 8'hFF;
  localparam phase_t COMMIT_PHASE  = 2'd3;
  localparam int     DOWNLOAD_HOLD = 255;
  localparam int     DITHER_BITS   = 12;

  // byte-wide write bus from the host bridge
  typedef struct packed {
    logic       wr;
    host_addr_t addr;
    byte_t      data;
  } host_write_t;

  // one access on the shared memory port
  typedef struct packed {
    logic      we;
    logic      re;
    mem_addr_t addr;
    byte_t     data;
  } mem_req_t;

endpackage

`default_nettype wire
